/* build.f */
cpu_pkg.sv
stage_ctrl.sv
bus_port.sv
decoder.sv
regfile.sv
execute_unit.sv
perf_counters.sv
cpu.sv
tb_mem.sv
tb_cpu.sv

/* bus_port.sv */
// bus_port: single outstanding request master for fetches and data accesses
`timescale 1ns/1ps
`default_nettype none

module bus_port (
  input  wire                       clk,
  input  wire                       i_rst,
  input  wire                       i_start,
  input  wire                       i_is_data,
  input  wire  [cpu_pkg::XLEN-1:0]  i_pc,
  input  cpu_pkg::bus_req_t         i_data_req,
  input  wire                       i_axi_io_ready,
  input  wire  [cpu_pkg::XLEN-1:0]  i_axi_io_rdata,
  output logic                      o_axi_io_valid,
  output logic                      o_axi_io_op,
  output logic [cpu_pkg::XLEN-1:0]  o_axi_io_addr,
  output logic [cpu_pkg::XLEN-1:0]  o_axi_io_wdata,
  output logic                      o_done,
  output logic [cpu_pkg::XLEN-1:0]  o_rdata
);

  cpu_pkg::bus_req_t req_q;
  cpu_pkg::bus_req_t fetch_req;
  logic              valid_q;
  logic              done_q;

  assign fetch_req = '{op: 1'b0, addr: i_pc, wdata: '0};

  always_ff @(posedge clk) begin
    if (i_rst) begin
      valid_q <= 1'b0;
      done_q  <= 1'b0;
    end else begin
      done_q <= valid_q && i_axi_io_ready;
      if (valid_q && i_axi_io_ready) begin
        valid_q <= 1'b0;
      end else if (i_start) begin
        valid_q <= 1'b1;
      end
    end
  end

  // request fields hold while valid is up
  always_ff @(posedge clk) begin
    if (i_start && !valid_q) begin
      req_q <= i_is_data ? i_data_req : fetch_req;
    end
    if (valid_q && i_axi_io_ready) begin
      o_rdata <= i_axi_io_rdata;
    end
  end

  assign o_axi_io_valid = valid_q;
  assign o_axi_io_op    = req_q.op;
  assign o_axi_io_addr  = req_q.addr;
  assign o_axi_io_wdata = req_q.wdata;
  assign o_done         = done_q;

endmodule

`default_nettype wire

/* cpu.sv */
// cpu: top of the multi-cycle rv64i core with one shared memory bus
`timescale 1ns/1ps
`default_nettype none

module cpu (
  input  wire                       clk,
  input  wire                       i_rst,

  // memory bus
  input  wire                       i_axi_io_ready,
  input  wire  [cpu_pkg::XLEN-1:0]  i_axi_io_rdata,
  output wire                       o_axi_io_valid,
  output wire                       o_axi_io_op,
  output wire  [cpu_pkg::XLEN-1:0]  o_axi_io_addr,
  output wire  [cpu_pkg::XLEN-1:0]  o_axi_io_wdata,

  output wire                       o_putch_valid,
  output wire  [7:0]                o_putch_data,
  output cpu_pkg::perf_t            o_perf
);

  cpu_pkg::stage_e                stage;
  logic                           bus_start;
  logic                           bus_is_data;
  logic                           bus_done;
  logic [cpu_pkg::XLEN-1:0]       bus_rdata;
  cpu_pkg::decoded_t              dec;
  logic [cpu_pkg::XLEN-1:0]       rs1_data;
  logic [cpu_pkg::XLEN-1:0]       rs2_data;
  logic [cpu_pkg::XLEN-1:0]       pc;
  cpu_pkg::bus_req_t              data_req;
  logic                           rd_wen;
  logic [cpu_pkg::XLEN-1:0]       rd_wdata;
  logic                           retire;

  stage_ctrl stage_ctrl_i (
    .clk            (clk            ),
    .i_rst          (i_rst          ),
    .i_dec          (dec            ),
    .i_bus_done     (bus_done       ),
    .o_stage        (stage          ),
    .o_bus_start    (bus_start      ),
    .o_bus_is_data  (bus_is_data    ),
    .o_retire       (retire         ),
    .o_putch_valid  (o_putch_valid  )
  );

  bus_port bus_port_i (
    .clk            (clk            ),
    .i_rst          (i_rst          ),
    .i_start        (bus_start      ),
    .i_is_data      (bus_is_data    ),
    .i_pc           (pc             ),
    .i_data_req     (data_req       ),
    .i_axi_io_ready (i_axi_io_ready ),
    .i_axi_io_rdata (i_axi_io_rdata ),
    .o_axi_io_valid (o_axi_io_valid ),
    .o_axi_io_op    (o_axi_io_op    ),
    .o_axi_io_addr  (o_axi_io_addr  ),
    .o_axi_io_wdata (o_axi_io_wdata ),
    .o_done         (bus_done       ),
    .o_rdata        (bus_rdata      )
  );

  decoder decoder_i (
    .clk            (clk                            ),
    .i_rst          (i_rst                          ),
    .i_stage        (stage                          ),
    .i_inst         (bus_rdata[cpu_pkg::ILEN-1:0]   ),
    .o_dec          (dec                            )
  );

  regfile regfile_i (
    .clk            (clk            ),
    .i_rst          (i_rst          ),
    .i_rs1          (dec.rs1        ),
    .i_rs2          (dec.rs2        ),
    .i_wen          (rd_wen         ),
    .i_rd           (dec.rd         ),
    .i_wdata        (rd_wdata       ),
    .o_rs1_data     (rs1_data       ),
    .o_rs2_data     (rs2_data       )
  );

  execute_unit execute_unit_i (
    .clk            (clk            ),
    .i_rst          (i_rst          ),
    .i_stage        (stage          ),
    .i_dec          (dec            ),
    .i_rs1_data     (rs1_data       ),
    .i_rs2_data     (rs2_data       ),
    .i_load_data    (bus_rdata      ),
    .o_pc           (pc             ),
    .o_data_req     (data_req       ),
    .o_rd_wen       (rd_wen         ),
    .o_rd_wdata     (rd_wdata       ),
    .o_putch_data   (o_putch_data   )
  );

  perf_counters perf_counters_i (
    .clk            (clk            ),
    .i_rst          (i_rst          ),
    .i_retire       (retire         ),
    .o_perf         (o_perf         )
  );

endmodule

`default_nettype wire

/* cpu_pkg.sv */
// cpu_pkg: widths, opcodes, reset values and shared types of the rv64i core
`default_nettype none

package cpu_pkg;

  localparam int XLEN      = 64;
  localparam int ILEN      = 32;
  localparam int REG_IDX_W = 5;

  localparam logic [XLEN-1:0]      RESET_PC   = 64'h0;
  localparam logic [ILEN-1:0]      PUTCH_INST = 32'h7b;
  localparam logic [REG_IDX_W-1:0] PUTCH_REG  = 5'd10;

  ////////////////////////////////////////////////////////////
  // encodings
  ////////////////////////////////////////////////////////////

  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_LOAD   = 7'b0000011;
  localparam logic [6:0] OPC_STORE  = 7'b0100011;
  localparam logic [6:0] OPC_BRANCH = 7'b1100011;
  localparam logic [6:0] OPC_JAL    = 7'b1101111;

  localparam logic [2:0] F3_ADD_SUB = 3'b000;
  localparam logic [2:0] F3_XOR     = 3'b100;
  localparam logic [2:0] F3_OR      = 3'b110;
  localparam logic [2:0] F3_AND     = 3'b111;
  // ld and sd share it
  localparam logic [2:0] F3_DWORD   = 3'b011;
  localparam logic [2:0] F3_BEQ     = 3'b000;
  localparam logic [2:0] F3_BNE     = 3'b001;

  ////////////////////////////////////////////////////////////
  // types
  ////////////////////////////////////////////////////////////

  typedef enum logic [3:0] {
    KIND_ALU_IMM,
    KIND_ALU_REG,
    KIND_LOAD,
    KIND_STORE,
    KIND_BRANCH,
    KIND_JAL,
    KIND_PUTCH,
    KIND_ILLEGAL
  } inst_kind_e;

  typedef struct packed {
    inst_kind_e           kind;
    logic [REG_IDX_W-1:0] rs1;
    logic [REG_IDX_W-1:0] rs2;
    logic [REG_IDX_W-1:0] rd;
    logic                 rd_wen;
    logic [2:0]           funct3;
    logic                 funct7_b5;
    logic [XLEN-1:0]      imm;
  } decoded_t;

  // op high means write
  typedef struct packed {
    logic            op;
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] wdata;
  } bus_req_t;

  typedef struct packed {
    logic [63:0] mcycle;
    logic [63:0] minstret;
  } perf_t;

  typedef enum logic [2:0] {
    ST_IF,
    ST_ID,
    ST_EX,
    ST_MEM,
    ST_WB
  } stage_e;

endpackage

`default_nettype wire

/* decoder.sv */
// decoder: classifies the fetched instruction and registers its fields in id
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  wire                       clk,
  input  wire                       i_rst,
  input  cpu_pkg::stage_e           i_stage,
  input  wire  [cpu_pkg::ILEN-1:0]  i_inst,
  output cpu_pkg::decoded_t         o_dec
);

  cpu_pkg::decoded_t        dec_d;
  logic [6:0]               opcode;
  logic [6:0]               funct7;
  logic [cpu_pkg::XLEN-1:0] imm_i;
  logic [cpu_pkg::XLEN-1:0] imm_s;
  logic [cpu_pkg::XLEN-1:0] imm_b;
  logic [cpu_pkg::XLEN-1:0] imm_j;

  assign opcode = i_inst[6:0];
  assign funct7 = i_inst[31:25];

  ////////////////////////////////////////////////////////////
  // immediates, sign extended to xlen
  ////////////////////////////////////////////////////////////

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  always_comb begin
    dec_d           = '0;
    dec_d.kind      = cpu_pkg::KIND_ILLEGAL;
    dec_d.rs1       = i_inst[19:15];
    dec_d.rs2       = i_inst[24:20];
    dec_d.rd        = i_inst[11:7];
    dec_d.funct3    = i_inst[14:12];
    dec_d.funct7_b5 = i_inst[30];

    case (opcode)
      cpu_pkg::OPC_OP_IMM: begin
        if (dec_d.funct3 == cpu_pkg::F3_ADD_SUB) begin
          dec_d.kind = cpu_pkg::KIND_ALU_IMM;
          dec_d.imm  = imm_i;
        end
      end
      cpu_pkg::OPC_OP: begin
        // only sub may carry funct7 bit 5
        if ((funct7 == 7'b0) || ((funct7 == 7'b0100000) &&
            (dec_d.funct3 == cpu_pkg::F3_ADD_SUB))) begin
          if (dec_d.funct3 inside {cpu_pkg::F3_ADD_SUB, cpu_pkg::F3_XOR,
                                   cpu_pkg::F3_OR, cpu_pkg::F3_AND}) begin
            dec_d.kind = cpu_pkg::KIND_ALU_REG;
          end
        end
      end
      cpu_pkg::OPC_LOAD: begin
        if (dec_d.funct3 == cpu_pkg::F3_DWORD) begin
          dec_d.kind = cpu_pkg::KIND_LOAD;
          dec_d.imm  = imm_i;
        end
      end
      cpu_pkg::OPC_STORE: begin
        if (dec_d.funct3 == cpu_pkg::F3_DWORD) begin
          dec_d.kind = cpu_pkg::KIND_STORE;
          dec_d.imm  = imm_s;
        end
      end
      cpu_pkg::OPC_BRANCH: begin
        if (dec_d.funct3 inside {cpu_pkg::F3_BEQ, cpu_pkg::F3_BNE}) begin
          dec_d.kind = cpu_pkg::KIND_BRANCH;
          dec_d.imm  = imm_b;
        end
      end
      cpu_pkg::OPC_JAL: begin
        dec_d.kind = cpu_pkg::KIND_JAL;
        dec_d.imm  = imm_j;
      end
      default: ;
    endcase

    // putch reads a0
    if (i_inst == cpu_pkg::PUTCH_INST) begin
      dec_d.kind = cpu_pkg::KIND_PUTCH;
      dec_d.rs1  = cpu_pkg::PUTCH_REG;
    end

    dec_d.rd_wen = (dec_d.rd != '0) &&
                   (dec_d.kind inside {cpu_pkg::KIND_ALU_IMM, cpu_pkg::KIND_ALU_REG,
                                       cpu_pkg::KIND_LOAD, cpu_pkg::KIND_JAL});
  end

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_dec.kind   <= cpu_pkg::KIND_ILLEGAL;
      o_dec.rd_wen <= 1'b0;
    end else if (i_stage == cpu_pkg::ST_ID) begin
      o_dec <= dec_d;
    end
  end

endmodule

`default_nettype wire

/* execute_unit.sv */
// execute_unit: alu, branch decision, pc and write-back value of the core
`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire                       clk,
  input  wire                       i_rst,
  input  cpu_pkg::stage_e           i_stage,
  input  cpu_pkg::decoded_t         i_dec,
  input  wire  [cpu_pkg::XLEN-1:0]  i_rs1_data,
  input  wire  [cpu_pkg::XLEN-1:0]  i_rs2_data,
  input  wire  [cpu_pkg::XLEN-1:0]  i_load_data,
  output logic [cpu_pkg::XLEN-1:0]  o_pc,
  output cpu_pkg::bus_req_t         o_data_req,
  output logic                      o_rd_wen,
  output logic [cpu_pkg::XLEN-1:0]  o_rd_wdata,
  output logic [7:0]                o_putch_data
);

  logic [cpu_pkg::XLEN-1:0] pc_q;
  logic [cpu_pkg::XLEN-1:0] next_pc;
  logic [cpu_pkg::XLEN-1:0] sum_imm;
  logic [cpu_pkg::XLEN-1:0] alu_res;
  logic [cpu_pkg::XLEN-1:0] result_q;
  logic [cpu_pkg::XLEN-1:0] target_q;
  logic                     taken_d;
  logic                     taken_q;

  // addi result and load/store address
  assign sum_imm = i_rs1_data + i_dec.imm;

  always_comb begin
    alu_res = '0;
    taken_d = 1'b0;
    case (i_dec.kind)
      cpu_pkg::KIND_ALU_IMM: alu_res = sum_imm;
      cpu_pkg::KIND_ALU_REG: begin
        case (i_dec.funct3)
          cpu_pkg::F3_ADD_SUB: begin
            alu_res = i_dec.funct7_b5 ? (i_rs1_data - i_rs2_data)
                                      : (i_rs1_data + i_rs2_data);
          end
          cpu_pkg::F3_XOR: alu_res = i_rs1_data ^ i_rs2_data;
          cpu_pkg::F3_OR:  alu_res = i_rs1_data | i_rs2_data;
          cpu_pkg::F3_AND: alu_res = i_rs1_data & i_rs2_data;
          default:         alu_res = '0;
        endcase
      end
      cpu_pkg::KIND_BRANCH: begin
        taken_d = (i_dec.funct3 == cpu_pkg::F3_BNE) ? (i_rs1_data != i_rs2_data)
                                                    : (i_rs1_data == i_rs2_data);
      end
      cpu_pkg::KIND_JAL: begin
        alu_res = pc_q + 64'd4;
        taken_d = 1'b1;
      end
      cpu_pkg::KIND_PUTCH: alu_res = {56'd0, i_rs1_data[7:0]};
      default: ;
    endcase
  end

  ////////////////////////////////////////////////////////////
  // ex captures, wb moves the pc
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (i_rst) begin
      pc_q    <= cpu_pkg::RESET_PC;
      taken_q <= 1'b0;
    end else if (i_stage == cpu_pkg::ST_EX) begin
      taken_q <= taken_d;
    end else if (i_stage == cpu_pkg::ST_WB) begin
      pc_q <= next_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (i_stage == cpu_pkg::ST_EX) begin
      result_q <= alu_res;
      target_q <= pc_q + i_dec.imm;
    end
  end

  assign next_pc = taken_q ? target_q : (pc_q + 64'd4);

  // the fetch issued in wb already needs the next pc
  assign o_pc = (i_stage == cpu_pkg::ST_WB) ? next_pc : pc_q;

  assign o_data_req = '{op:    (i_dec.kind == cpu_pkg::KIND_STORE),
                        addr:  sum_imm,
                        wdata: i_rs2_data};

  assign o_rd_wen     = (i_stage == cpu_pkg::ST_WB) && i_dec.rd_wen;
  assign o_rd_wdata   = (i_dec.kind == cpu_pkg::KIND_LOAD) ? i_load_data : result_q;
  assign o_putch_data = result_q[7:0];

endmodule

`default_nettype wire

/* perf_counters.sv */
// perf_counters: mcycle and minstret style cycle and retire counters
`timescale 1ns/1ps
`default_nettype none

module perf_counters (
  input  wire             clk,
  input  wire             i_rst,
  input  wire             i_retire,
  output cpu_pkg::perf_t  o_perf
);

  always_ff @(posedge clk) begin
    if (i_rst) begin
      o_perf <= '0;
    end else begin
      o_perf.mcycle   <= o_perf.mcycle + 64'd1;
      o_perf.minstret <= o_perf.minstret + {63'd0, i_retire};
    end
  end

endmodule

`default_nettype wire

/* regfile.sv */
// regfile holds 32 x 64 integer registers with two async reads and one sync write
`timescale 1ns/1ps
`default_nettype none

module regfile (
  input  wire                            clk,
  input  wire                            i_rst,
  input  wire  [cpu_pkg::REG_IDX_W-1:0]  i_rs1,
  input  wire  [cpu_pkg::REG_IDX_W-1:0]  i_rs2,
  input  wire                            i_wen,
  input  wire  [cpu_pkg::REG_IDX_W-1:0]  i_rd,
  input  wire  [cpu_pkg::XLEN-1:0]       i_wdata,
  output logic [cpu_pkg::XLEN-1:0]       o_rs1_data,
  output logic [cpu_pkg::XLEN-1:0]       o_rs2_data
);

  localparam int NREGS = 2 ** cpu_pkg::REG_IDX_W;

  logic [cpu_pkg::XLEN-1:0] regs [NREGS];

  // x0 is never written and keeps its reset value of zero
  always_ff @(posedge clk) begin
    if (i_rst) begin
      for (int i = 0; i < NREGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_rd != '0)) begin
      regs[i_rd] <= i_wdata;
    end
  end

  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

endmodule

`default_nettype wire

/* stage_ctrl.sv */
// stage_ctrl: steps one instruction at a time through if, id, ex, mem and wb
`timescale 1ns/1ps
`default_nettype none

module stage_ctrl (
  input  wire                clk,
  input  wire                i_rst,
  input  cpu_pkg::decoded_t  i_dec,
  input  wire                i_bus_done,
  output cpu_pkg::stage_e    o_stage,
  output logic               o_bus_start,
  output logic               o_bus_is_data,
  output logic               o_retire,
  output logic               o_putch_valid
);

  cpu_pkg::stage_e state_q;
  cpu_pkg::stage_e state_d;
  logic            boot_q;
  logic            is_mem;

  assign is_mem = (i_dec.kind == cpu_pkg::KIND_LOAD) ||
                  (i_dec.kind == cpu_pkg::KIND_STORE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      cpu_pkg::ST_IF: begin
        if (i_bus_done) begin
          state_d = cpu_pkg::ST_ID;
        end
      end
      cpu_pkg::ST_ID:  state_d = cpu_pkg::ST_EX;
      cpu_pkg::ST_EX:  state_d = is_mem ? cpu_pkg::ST_MEM : cpu_pkg::ST_WB;
      cpu_pkg::ST_MEM: begin
        if (i_bus_done) begin
          state_d = cpu_pkg::ST_WB;
        end
      end
      cpu_pkg::ST_WB:  state_d = cpu_pkg::ST_IF;
      default:         state_d = cpu_pkg::ST_IF;
    endcase
  end

  // boot_q kicks off the very first fetch
  always_ff @(posedge clk) begin
    if (i_rst) begin
      state_q <= cpu_pkg::ST_IF;
      boot_q  <= 1'b1;
    end else begin
      state_q <= state_d;
      boot_q  <= 1'b0;
    end
  end

  assign o_stage = state_q;

  // request goes out as the state enters if or mem
  assign o_bus_start   = boot_q || (state_q == cpu_pkg::ST_WB) ||
                         ((state_q == cpu_pkg::ST_EX) && is_mem);
  assign o_bus_is_data = (state_q == cpu_pkg::ST_EX);

  assign o_retire      = (state_q == cpu_pkg::ST_WB);
  assign o_putch_valid = (state_q == cpu_pkg::ST_WB) &&
                         (i_dec.kind == cpu_pkg::KIND_PUTCH);

endmodule

`default_nettype wire

/* tb_cpu.sv */
// tb_cpu: directed tests of the rv64i core running small programs from tb_mem
`timescale 1ns/1ps
`default_nettype none

module tb_cpu;

  localparam logic [63:0] MARK_ADDR = 64'h3f8;
  // 7 runs, under 20 instructions each, 13 cycles per instruction at worst
  localparam int RUNS        = 7;
  localparam int RUN_CYCLES  = 20 * 13 + 10;
  localparam int CYCLE_LIMIT = 2 * RUNS * RUN_CYCLES;

  logic           clk;
  logic           i_rst;
  wire            ready;
  wire  [63:0]    rdata;
  wire            valid;
  wire            op;
  wire  [63:0]    addr;
  wire  [63:0]    wdata;
  wire            putch_valid;
  wire  [7:0]     putch_data;
  cpu_pkg::perf_t perf;

  logic [31:0] prog[$];
  logic [63:0] exp_addr[$];
  logic [63:0] exp_data[$];
  logic [63:0] pre_addr[$];
  logic [63:0] pre_data[$];
  logic [7:0]  putch_seen[$];
  logic [63:0] loop_pc;
  int          errors;
  int          tests_run;
  int          cycle_cnt;

  cpu cpu_i (
    .clk            (clk        ),
    .i_rst          (i_rst      ),
    .i_axi_io_ready (ready      ),
    .i_axi_io_rdata (rdata      ),
    .o_axi_io_valid (valid      ),
    .o_axi_io_op    (op         ),
    .o_axi_io_addr  (addr       ),
    .o_axi_io_wdata (wdata      ),
    .o_putch_valid  (putch_valid),
    .o_putch_data   (putch_data ),
    .o_perf         (perf       )
  );

  tb_mem tb_mem_i (
    .clk     (clk  ),
    .i_valid (valid),
    .i_op    (op   ),
    .i_addr  (addr ),
    .i_wdata (wdata),
    .o_ready (ready),
    .o_rdata (rdata)
  );

  always #2 clk = ~clk;

  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt > CYCLE_LIMIT) begin
      $display("Timeout: the core did not finish its programs within %0d cycles", CYCLE_LIMIT);
      $display("tests run: %0d, errors: %0d", tests_run, errors + 1);
      $display("Something failed");
      $finish;
    end
  end

  // wb lasts one cycle, so one sample per pulse
  always @(negedge clk) begin
    if (putch_valid === 1'b1) begin
      putch_seen.push_back(putch_data);
    end
  end

  ////////////////////////////////////////////////////////////
  // instruction encoders
  ////////////////////////////////////////////////////////////

  function automatic logic [31:0] addi_inst(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b000, rd[4:0], 7'b0010011};
  endfunction

  function automatic logic [31:0] rtype_inst(input int rd, input int rs1, input int rs2,
                                             input int f3, input int f7);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'b0110011};
  endfunction

  function automatic logic [31:0] ld_inst(input int rd, input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], 3'b011, rd[4:0], 7'b0000011};
  endfunction

  function automatic logic [31:0] sd_inst(input int rs2, input int rs1, input int imm);
    return {imm[11:5], rs2[4:0], rs1[4:0], 3'b011, imm[4:0], 7'b0100011};
  endfunction

  // f3 0 is beq, 1 is bne
  function automatic logic [31:0] branch_inst(input int f3, input int rs1, input int rs2,
                                              input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11],
            7'b1100011};
  endfunction

  function automatic logic [31:0] jal_inst(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], 7'b1101111};
  endfunction

  ////////////////////////////////////////////////////////////
  // program building and running
  ////////////////////////////////////////////////////////////

  task automatic new_program();
    prog.delete();
    exp_addr.delete();
    exp_data.delete();
    pre_addr.delete();
    pre_data.delete();
  endtask

  task automatic expect_store(input logic [63:0] a, input logic [63:0] d);
    exp_addr.push_back(a);
    exp_data.push_back(d);
  endtask

  // marker store, then a jump to itself
  task automatic end_program();
    prog.push_back(addi_inst(8, 0, 'h5a));
    prog.push_back(sd_inst(8, 0, MARK_ADDR));
    prog.push_back(jal_inst(0, 0));
    expect_store(MARK_ADDR, 64'h5a);
  endtask

  task automatic report_mismatch(input string test, input string what,
                                 input logic [63:0] exp, input logic [63:0] act);
    errors++;
    $display("Mismatch in %s, %s: expected %h, actual %h", test, what, exp, act);
  endtask

  task automatic check_reset_outputs(input string name);
    if (valid !== 1'b0) report_mismatch(name, "valid in reset", 0, valid);
    if (putch_valid !== 1'b0) report_mismatch(name, "putch in reset", 0, putch_valid);
    if (perf.mcycle !== 64'd0) report_mismatch(name, "mcycle in reset", 0, perf.mcycle);
    if (perf.minstret !== 64'd0) report_mismatch(name, "minstret in reset", 0, perf.minstret);
  endtask

  task automatic run_program(input string name, input bit fast_mem,
                             output logic [63:0] cycles, output logic [63:0] instret);
    int          waited;
    logic [63:0] start_cycle;
    tests_run++;
    putch_seen.delete();
    @(negedge clk);
    i_rst = 1'b1;
    @(negedge clk);
    tb_mem_i.fill(fast_mem);
    foreach (prog[i]) tb_mem_i.put_inst(4 * i, prog[i]);
    foreach (pre_addr[i]) tb_mem_i.put_word(pre_addr[i], pre_data[i]);
    loop_pc = 4 * (prog.size() - 1);
    check_reset_outputs(name);
    @(negedge clk);
    check_reset_outputs(name);
    i_rst = 1'b0;
    waited = 0;
    while (valid !== 1'b1 && waited < 2) begin
      @(negedge clk);
      waited++;
    end
    if (valid !== 1'b1) begin
      errors++;
      $display("%s: no fetch request within two cycles after reset", name);
    end else begin
      if (addr !== cpu_pkg::RESET_PC) report_mismatch(name, "first fetch addr", 0, addr);
      if (op !== 1'b0) report_mismatch(name, "first fetch op", 0, op);
    end
    start_cycle = perf.mcycle;
    while (!(valid === 1'b1 && op === 1'b0 && addr === loop_pc)) @(negedge clk);
    cycles  = perf.mcycle - start_cycle;
    instret = perf.minstret;
  endtask

  task automatic check_stores(input string name);
    if (tb_mem_i.log_count != exp_addr.size()) begin
      report_mismatch(name, "store count", exp_addr.size(), tb_mem_i.log_count);
    end
    foreach (exp_addr[k]) begin
      if (k < tb_mem_i.log_count) begin
        if (tb_mem_i.log_addr[k] !== exp_addr[k]) begin
          report_mismatch(name, "store addr", exp_addr[k], tb_mem_i.log_addr[k]);
        end
        if (tb_mem_i.log_data[k] !== exp_data[k]) begin
          report_mismatch(name, "store data", exp_data[k], tb_mem_i.log_data[k]);
        end
      end
    end
  endtask

  ////////////////////////////////////////////////////////////
  // programs
  ////////////////////////////////////////////////////////////

  task automatic build_arith();
    logic [63:0] r [8];
    r[0] = 64'd0;
    r[1] = -64'd3;
    r[2] = 64'h555;
    r[3] = r[1] + r[2];
    r[4] = r[2] - r[1];
    r[5] = r[1] & r[2];
    r[6] = r[1] | r[2];
    r[7] = r[1] ^ r[2];
    prog.push_back(addi_inst(1, 0, -3));
    prog.push_back(addi_inst(2, 0, 'h555));
    prog.push_back(rtype_inst(3, 1, 2, 0, 0));
    prog.push_back(rtype_inst(4, 2, 1, 0, 'h20));
    prog.push_back(rtype_inst(5, 1, 2, 7, 0));
    prog.push_back(rtype_inst(6, 1, 2, 6, 0));
    prog.push_back(rtype_inst(7, 1, 2, 4, 0));
    // x0 must ignore this
    prog.push_back(addi_inst(0, 1, 5));
    for (int k = 1; k < 8; k++) begin
      prog.push_back(sd_inst(k, 0, 'h200 + 8 * (k - 1)));
      expect_store(64'h200 + 8 * (k - 1), r[k]);
    end
    prog.push_back(sd_inst(0, 0, 'h238));
    expect_store(64'h238, r[0]);
    end_program();
  endtask

  task automatic build_load_store();
    pre_addr.push_back(64'h210);
    pre_data.push_back(64'h0123_4567_89ab_cdef);
    prog.push_back(addi_inst(1, 0, 'h123));
    prog.push_back(addi_inst(2, 0, -1024));
    prog.push_back(sd_inst(1, 0, 'h200));
    prog.push_back(ld_inst(3, 0, 'h200));
    prog.push_back(addi_inst(3, 3, 'h10));
    prog.push_back(rtype_inst(4, 3, 2, 0, 0));
    prog.push_back(sd_inst(4, 0, 'h208));
    prog.push_back(ld_inst(5, 0, 'h210));
    prog.push_back(sd_inst(5, 0, 'h218));
    expect_store(64'h200, 64'h123);
    expect_store(64'h208, 64'h133 + (-64'd1024));
    expect_store(64'h218, 64'h0123_4567_89ab_cdef);
    end_program();
  endtask

  ////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////

  task automatic test_reset();
    logic [63:0] cycles;
    logic [63:0] instret;
    new_program();
    end_program();
    run_program("reset", 1'b1, cycles, instret);
    check_stores("reset");
    if (instret !== 64'd2) report_mismatch("reset", "minstret", 2, instret);
  endtask

  task automatic test_arith();
    logic [63:0] cycles;
    logic [63:0] instret;
    new_program();
    build_arith();
    run_program("arith", 1'b1, cycles, instret);
    check_stores("arith");
  endtask

  task automatic test_load_store();
    logic [63:0] cycles;
    logic [63:0] instret;
    new_program();
    build_load_store();
    run_program("load_store", 1'b1, cycles, instret);
    check_stores("load_store");
    for (int k = 0; k < 3; k++) begin
      if (tb_mem_i.peek(exp_addr[k]) !== exp_data[k]) begin
        report_mismatch("load_store", "memory word", exp_data[k], tb_mem_i.peek(exp_addr[k]));
      end
    end
  endtask

  task automatic test_control();
    logic [63:0] cycles;
    logic [63:0] instret;
    logic [63:0] jal_pc;
    new_program();
    prog.push_back(addi_inst(1, 0, 5));
    prog.push_back(addi_inst(2, 0, 5));
    prog.push_back(branch_inst(0, 1, 2, 8));
    prog.push_back(sd_inst(1, 0, 'h220));
    prog.push_back(branch_inst(1, 1, 2, 8));
    prog.push_back(sd_inst(2, 0, 'h228));
    prog.push_back(addi_inst(3, 0, 7));
    prog.push_back(branch_inst(1, 1, 3, 8));
    prog.push_back(sd_inst(3, 0, 'h230));
    prog.push_back(branch_inst(0, 1, 3, 8));
    prog.push_back(sd_inst(3, 0, 'h238));
    jal_pc = 4 * prog.size();
    prog.push_back(jal_inst(4, 8));
    prog.push_back(sd_inst(0, 0, 'h240));
    prog.push_back(sd_inst(4, 0, 'h248));
    // skipped stores at 0x220, 0x230 and 0x240
    expect_store(64'h228, 64'd5);
    expect_store(64'h238, 64'd7);
    expect_store(64'h248, jal_pc + 4);
    end_program();
    run_program("control", 1'b1, cycles, instret);
    check_stores("control");
  endtask

  task automatic test_putch();
    logic [63:0] cycles;
    logic [63:0] instret;
    logic [7:0]  exp_chars[$];
    int          vals[3] = '{'h74f, 'h34b, 'h021};
    new_program();
    foreach (vals[i]) begin
      prog.push_back(addi_inst(10, 0, vals[i]));
      prog.push_back(32'h0000007b);
      exp_chars.push_back(vals[i][7:0]);
    end
    end_program();
    run_program("putch", 1'b1, cycles, instret);
    check_stores("putch");
    if (putch_seen.size() != exp_chars.size()) begin
      report_mismatch("putch", "char count", exp_chars.size(), putch_seen.size());
    end
    foreach (exp_chars[i]) begin
      if (i < putch_seen.size() && putch_seen[i] !== exp_chars[i]) begin
        report_mismatch("putch", "char", exp_chars[i], putch_seen[i]);
      end
    end
  endtask

  task automatic test_backpressure();
    logic [63:0] cycles;
    logic [63:0] instret;
    logic [63:0] exp_cycles;
    new_program();
    build_arith();
    run_program("backpressure", 1'b0, cycles, instret);
    check_stores("backpressure");
    if (instret !== prog.size() - 1) report_mismatch("backpressure", "minstret",
                                                     prog.size() - 1, instret);
    new_program();
    build_load_store();
    run_program("counters", 1'b1, cycles, instret);
    check_stores("counters");
    exp_cycles = 0;
    for (int i = 0; i < prog.size() - 1; i++) begin
      if (prog[i][6:0] == 7'b0000011 || prog[i][6:0] == 7'b0100011) begin
        exp_cycles += 7;
      end else begin
        exp_cycles += 5;
      end
    end
    if (cycles !== exp_cycles) report_mismatch("counters", "mcycle", exp_cycles, cycles);
    if (instret !== prog.size() - 1) report_mismatch("counters", "minstret",
                                                     prog.size() - 1, instret);
  endtask

  initial begin
    clk       = 1'b0;
    i_rst     = 1'b1;
    errors    = 0;
    tests_run = 0;
    cycle_cnt = 0;
    test_reset();
    test_arith();
    test_load_store();
    test_control();
    test_putch();
    test_backpressure();
    $display("tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* tb_mem.sv */
// tb_mem: behavioral memory that answers core bus requests after a random delay
`timescale 1ns/1ps
`default_nettype none

module tb_mem (
  input  wire         clk,
  input  wire         i_valid,
  input  wire         i_op,
  input  wire  [63:0] i_addr,
  input  wire  [63:0] i_wdata,
  output logic        o_ready,
  output logic [63:0] o_rdata
);

  localparam int WORDS   = 128;
  localparam int LOG_MAX = 64;

  logic [63:0] mem [WORDS];
  logic [63:0] log_addr [LOG_MAX];
  logic [63:0] log_data [LOG_MAX];
  int          log_count;
  integer      seed;
  bit          fast;
  bit          busy;
  int          wait_left;
  logic [6:0]  idx;

  initial begin
    seed      = 32'h69ceb2ea;
    fast      = 1'b1;
    busy      = 1'b0;
    wait_left = 0;
    log_count = 0;
    o_ready   = 1'b0;
    o_rdata   = '0;
  end

  // pattern spreads the whole address over the word
  task automatic fill(input bit fast_mem);
    logic [63:0] a;
    for (int i = 0; i < WORDS; i++) begin
      a = 64'(i) * 8;
      mem[i] = {a[31:0] ^ 32'h5a5a_5a5a, ~a[31:0]};
    end
    log_count = 0;
    fast      = fast_mem;
  endtask

  task automatic put_inst(input logic [63:0] a, input logic [31:0] inst);
    if (a[2]) begin
      mem[a[9:3]][63:32] = inst;
    end else begin
      mem[a[9:3]][31:0] = inst;
    end
  endtask

  task automatic put_word(input logic [63:0] a, input logic [63:0] d);
    mem[a[9:3]] = d;
  endtask

  function automatic logic [63:0] peek(input logic [63:0] a);
    return mem[a[9:3]];
  endfunction

  assign idx = i_addr[9:3];

  ////////////////////////////////////////////////////////////
  // request handling, ready rises after the drawn delay
  ////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    if (i_valid && !o_ready) begin
      if (!busy) begin
        busy      = 1'b1;
        wait_left = fast ? 0 : int'($unsigned($random(seed)) % 4);
      end
      if (wait_left == 0) begin
        busy = 1'b0;
        o_ready <= 1'b1;
        // fetch of the upper half comes back in the low bits
        o_rdata <= i_addr[2] ? {32'h0, mem[idx][63:32]} : mem[idx];
        if (i_op) begin
          mem[idx] = i_wdata;
          if (log_count < LOG_MAX) begin
            log_addr[log_count] = i_addr;
            log_data[log_count] = i_wdata;
          end
          log_count++;
        end
      end else begin
        wait_left--;
      end
    end else begin
      busy = 1'b0;
      o_ready <= 1'b0;
    end
  end

endmodule

`default_nettype wire
